/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timescale 1ns/1ps
TOP       ?= tb_mpmem
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SRCS := $(filter-out +%,$(shell cat compile.f))
HDRS := $(wildcard logic/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): compile.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f compile.f

run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx 'Result: PASSED' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
+incdir+logic
logic/mpmem_pkg.sv
logic/bank_ram.sv
logic/init_sweep.sv
logic/bank_arbiter.sv
logic/request_pipe.sv
logic/parity_queue.sv
logic/read_return.sv
logic/mpmem_top.sv
test/tb_clock.sv
test/tb_mpmem.sv

/* logic/bank_arbiter.sv */
`timescale 1ns/1ps
`include "mpmem_defs.svh"

module bank_arbiter (
  input  logic                   ready,
  input  logic                   sweep_active,
  input  mpmem_pkg::row_t        sweep_row,
  input  logic                   wr_en,
  input  mpmem_pkg::addr_t       wr_addr,
  input  mpmem_pkg::data_t       wr_data,
  input  logic                   rd0_en,
  input  mpmem_pkg::addr_t       rd0_addr,
  input  logic                   rd1_en,
  input  mpmem_pkg::addr_t       rd1_addr,
  input  logic                   queue_valid,
  input  mpmem_pkg::row_t        queue_row,
  input  mpmem_pkg::data_t       queue_data,
  output mpmem_pkg::bank_mask_t  bank_we,
  output mpmem_pkg::bank_mask_t  bank_re,
  output mpmem_pkg::row_vec_t    bank_row,
  output mpmem_pkg::data_t       bank_wdata,
  output logic                   par_we,
  output logic                   par_re,
  output mpmem_pkg::row_t        par_row,
  output mpmem_pkg::data_t       par_wdata,
  output logic                   queue_deq,
  output logic                   wr_issue,
  output mpmem_pkg::bank_t       wr_bank,
  output mpmem_pkg::row_t        wr_row,
  output logic                   rd0_issue,
  output mpmem_pkg::bank_t       rd0_bank,
  output logic                   rd1_issue,
  output mpmem_pkg::bank_t       rd1_bank,
  output logic                   rd1_conflict
);

  mpmem_pkg::row_t rd0_row;
  mpmem_pkg::row_t rd1_row;

  assign wr_bank = wr_addr[`MPMEM_BANK_BITS-1:0];
  assign wr_row  = wr_addr[`MPMEM_ADDR_BITS-1:`MPMEM_BANK_BITS];
  assign rd0_bank = rd0_addr[`MPMEM_BANK_BITS-1:0];
  assign rd0_row  = rd0_addr[`MPMEM_ADDR_BITS-1:`MPMEM_BANK_BITS];
  assign rd1_bank = rd1_addr[`MPMEM_BANK_BITS-1:0];
  assign rd1_row  = rd1_addr[`MPMEM_ADDR_BITS-1:`MPMEM_BANK_BITS];

  assign wr_issue     = ready && wr_en;
  assign rd0_issue    = ready && !wr_en && rd0_en; // a write wins the cycle
  assign rd1_issue    = ready && !wr_en && rd1_en;
  assign rd1_conflict = rd0_issue && rd1_issue && (rd0_bank == rd1_bank);

  // parity bank drains whenever the reads cannot need it
  assign queue_deq = queue_valid && (!ready || wr_issue);
  assign par_we    = queue_deq;
  assign par_wdata = queue_data;
  assign par_re    = rd1_conflict;
  assign par_row   = rd1_conflict ? rd1_row : queue_row;

  always_comb begin
    bank_we    = '0;
    bank_re    = '0;
    bank_row   = '0;
    bank_wdata = wr_data;
    if (sweep_active) begin
      bank_we    = '1;
      bank_row   = {`MPMEM_NUM_BANKS{sweep_row}};
      bank_wdata = '0;
    end else if (wr_issue) begin
      bank_we  = mpmem_pkg::bank_mask_t'(1) << wr_bank;
      bank_re  = ~bank_we; // old row of the others feeds the parity update
      bank_row = {`MPMEM_NUM_BANKS{wr_row}};
    end else begin
      for (int i = 0; i < `MPMEM_NUM_BANKS; i++) begin
        if (rd0_issue && rd0_bank == mpmem_pkg::bank_t'(i)) begin
          bank_re[i]  = 1'b1;
          bank_row[i] = rd0_row;
        end
        if (rd1_conflict) begin
          if (rd1_bank != mpmem_pkg::bank_t'(i)) begin
            bank_re[i]  = 1'b1;
            bank_row[i] = rd1_row;
          end
        end else if (rd1_issue && rd1_bank == mpmem_pkg::bank_t'(i)) begin
          bank_re[i]  = 1'b1;
          bank_row[i] = rd1_row;
        end
      end
    end
  end

endmodule

/* logic/bank_ram.sv */
`timescale 1ns/1ps

module bank_ram #(
  parameter int width = 16,
  parameter int depth = 64
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic                     re,
  input  logic [$clog2(depth)-1:0] row,
  input  logic [width-1:0]         wdata,
  output logic [width-1:0]         rdata
);

  logic [width-1:0] mem [depth];
  logic [width-1:0] rd_q1;
  logic [width-1:0] rd_q2;

  // single port, the controller never reads and writes one bank together
  always_ff @(posedge clk) begin
    if (we)
      mem[row] <= wdata;
    if (re)
      rd_q1 <= mem[row];
    rd_q2 <= rd_q1; // second read stage
  end

  assign rdata = rd_q2;

endmodule

/* logic/init_sweep.sv */
`timescale 1ns/1ps
`include "mpmem_defs.svh"

module init_sweep (
  input  logic             clk,
  input  logic             rst,
  output logic             sweep_active,
  output mpmem_pkg::row_t  sweep_row,
  output logic             ready
);

  mpmem_pkg::sweep_state_t state;
  mpmem_pkg::row_t         row_cnt;
  logic [1:0]              settle_cnt; // counts the parity drain cycles

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= mpmem_pkg::sweep_clear;
      row_cnt    <= '0;
      settle_cnt <= '0;
    end else begin
      case (state)
        mpmem_pkg::sweep_clear: begin
          row_cnt <= row_cnt + 1'b1;
          if (row_cnt == mpmem_pkg::row_t'(`MPMEM_NUM_ROWS - 1))
            state <= mpmem_pkg::sweep_settle;
        end
        mpmem_pkg::sweep_settle: begin
          settle_cnt <= settle_cnt + 1'b1;
          if (settle_cnt == 2'(`MPMEM_SRAM_DELAY)) // last parity write has landed
            state <= mpmem_pkg::sweep_done;
        end
        default: state <= mpmem_pkg::sweep_done;
      endcase
    end
  end

  assign sweep_active = (state == mpmem_pkg::sweep_clear);
  assign sweep_row    = row_cnt;
  assign ready        = (state == mpmem_pkg::sweep_done);

endmodule

/* logic/mpmem_defs.svh */
`ifndef MPMEM_DEFS_SVH
`define MPMEM_DEFS_SVH

// data word width
`define MPMEM_WIDTH 16

// data bank count, bank number taken from the low address bits
`define MPMEM_NUM_BANKS 8
`define MPMEM_BANK_BITS 3

// rows per bank, row taken from the upper address bits
`define MPMEM_NUM_ROWS 64
`define MPMEM_ROW_BITS 6

`define MPMEM_ADDR_BITS 9

// read latency of every bank
`define MPMEM_SRAM_DELAY 2

// parity queue holds latency plus one updates
`define MPMEM_QUEUE_DEPTH 3

`endif

/* logic/mpmem_pkg.sv */
`include "mpmem_defs.svh"

package mpmem_pkg;

  typedef logic [`MPMEM_WIDTH-1:0]     data_t;
  typedef logic [`MPMEM_ROW_BITS-1:0]  row_t;
  typedef logic [`MPMEM_BANK_BITS-1:0] bank_t;
  typedef logic [`MPMEM_ADDR_BITS-1:0] addr_t;
  typedef logic [`MPMEM_NUM_BANKS-1:0] bank_mask_t;

  // one entry per data bank
  typedef row_t  [`MPMEM_NUM_BANKS-1:0] row_vec_t;
  typedef data_t [`MPMEM_NUM_BANKS-1:0] data_vec_t;

  typedef enum logic [1:0] {
    sweep_clear,
    sweep_settle,
    sweep_done
  } sweep_state_t;

endpackage

/* logic/mpmem_top.sv */
`timescale 1ns/1ps
`include "mpmem_defs.svh"

module mpmem_top (
  input  logic              clk,
  input  logic              rst,
  output logic              ready,
  input  logic              wr_en,
  input  mpmem_pkg::addr_t  wr_addr,
  input  mpmem_pkg::data_t  wr_data,
  input  logic              rd0_en,
  input  mpmem_pkg::addr_t  rd0_addr,
  input  logic              rd1_en,
  input  mpmem_pkg::addr_t  rd1_addr,
  output logic              rd0_valid,
  output mpmem_pkg::data_t  rd0_data,
  output logic              rd1_valid,
  output mpmem_pkg::data_t  rd1_data
);

  logic                  sweep_active;
  mpmem_pkg::row_t       sweep_row;
  logic                  queue_valid;
  mpmem_pkg::row_t       queue_row;
  mpmem_pkg::data_t      queue_data;
  logic                  queue_deq;
  mpmem_pkg::bank_mask_t bank_we;
  mpmem_pkg::bank_mask_t bank_re;
  mpmem_pkg::row_vec_t   bank_row;
  mpmem_pkg::data_t      bank_wdata;
  mpmem_pkg::data_vec_t  bank_rdata;
  logic                  par_we;
  logic                  par_re;
  mpmem_pkg::row_t       par_row;
  mpmem_pkg::data_t      par_wdata;
  mpmem_pkg::data_t      par_rdata;
  mpmem_pkg::data_t      par_word;
  logic                  wr_issue;
  mpmem_pkg::bank_t      wr_bank;
  mpmem_pkg::row_t       wr_row;
  logic                  rd0_issue;
  mpmem_pkg::bank_t      rd0_bank;
  logic                  rd1_issue;
  mpmem_pkg::bank_t      rd1_bank;
  logic                  rd1_conflict;
  logic                  wr_issue_out;
  mpmem_pkg::bank_t      wr_bank_out;
  mpmem_pkg::row_t       wr_row_out;
  mpmem_pkg::data_t      wr_data_out;
  logic                  rd0_issue_out;
  mpmem_pkg::bank_t      rd0_bank_out;
  logic                  rd1_issue_out;
  mpmem_pkg::bank_t      rd1_bank_out;
  logic                  rd1_conflict_out;

  init_sweep u_sweep (
    .clk(clk), .rst(rst), .sweep_active(sweep_active), .sweep_row(sweep_row), .ready(ready)
  );

  bank_arbiter u_arb (
    .ready(ready), .sweep_active(sweep_active), .sweep_row(sweep_row),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd0_en(rd0_en), .rd0_addr(rd0_addr), .rd1_en(rd1_en), .rd1_addr(rd1_addr),
    .queue_valid(queue_valid), .queue_row(queue_row), .queue_data(queue_data),
    .bank_we(bank_we), .bank_re(bank_re), .bank_row(bank_row), .bank_wdata(bank_wdata),
    .par_we(par_we), .par_re(par_re), .par_row(par_row), .par_wdata(par_wdata),
    .queue_deq(queue_deq),
    .wr_issue(wr_issue), .wr_bank(wr_bank), .wr_row(wr_row),
    .rd0_issue(rd0_issue), .rd0_bank(rd0_bank),
    .rd1_issue(rd1_issue), .rd1_bank(rd1_bank), .rd1_conflict(rd1_conflict)
  );

  request_pipe u_pipe (
    .clk(clk), .rst(rst),
    .wr_issue(wr_issue), .wr_bank(wr_bank), .wr_row(wr_row), .wr_data(wr_data),
    .rd0_issue(rd0_issue), .rd0_bank(rd0_bank),
    .rd1_issue(rd1_issue), .rd1_bank(rd1_bank), .rd1_conflict(rd1_conflict),
    .wr_issue_out(wr_issue_out), .wr_bank_out(wr_bank_out),
    .wr_row_out(wr_row_out), .wr_data_out(wr_data_out),
    .rd0_issue_out(rd0_issue_out), .rd0_bank_out(rd0_bank_out),
    .rd1_issue_out(rd1_issue_out), .rd1_bank_out(rd1_bank_out),
    .rd1_conflict_out(rd1_conflict_out)
  );

  parity_queue u_pq (
    .clk(clk), .rst(rst), .sweep_active(sweep_active), .sweep_row(sweep_row),
    .wr_issue_out(wr_issue_out), .wr_bank_out(wr_bank_out),
    .wr_row_out(wr_row_out), .wr_data_out(wr_data_out), .bank_rdata(bank_rdata),
    .queue_deq(queue_deq), .par_re(par_re), .par_row(par_row), .par_rdata(par_rdata),
    .queue_valid(queue_valid), .queue_row(queue_row), .queue_data(queue_data),
    .par_word(par_word)
  );

  read_return u_ret (
    .rd0_issue_out(rd0_issue_out), .rd0_bank_out(rd0_bank_out),
    .rd1_issue_out(rd1_issue_out), .rd1_bank_out(rd1_bank_out),
    .rd1_conflict_out(rd1_conflict_out), .bank_rdata(bank_rdata), .par_word(par_word),
    .rd0_valid(rd0_valid), .rd0_data(rd0_data), .rd1_valid(rd1_valid), .rd1_data(rd1_data)
  );

  for (genvar b = 0; b < `MPMEM_NUM_BANKS; b++) begin : g_bank
    bank_ram #(.width(`MPMEM_WIDTH), .depth(`MPMEM_NUM_ROWS)) u_ram (
      .clk(clk), .we(bank_we[b]), .re(bank_re[b]), .row(bank_row[b]),
      .wdata(bank_wdata), .rdata(bank_rdata[b])
    );
  end

  // xor of all data banks per row
  bank_ram #(.width(`MPMEM_WIDTH), .depth(`MPMEM_NUM_ROWS)) u_par_ram (
    .clk(clk), .we(par_we), .re(par_re), .row(par_row),
    .wdata(par_wdata), .rdata(par_rdata)
  );

endmodule

/* logic/parity_queue.sv */
`timescale 1ns/1ps
`include "mpmem_defs.svh"

module parity_queue (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  sweep_active,
  input  mpmem_pkg::row_t       sweep_row,
  input  logic                  wr_issue_out,
  input  mpmem_pkg::bank_t      wr_bank_out,
  input  mpmem_pkg::row_t       wr_row_out,
  input  mpmem_pkg::data_t      wr_data_out,
  input  mpmem_pkg::data_vec_t  bank_rdata,
  input  logic                  queue_deq,
  input  logic                  par_re,
  input  mpmem_pkg::row_t       par_row,
  input  mpmem_pkg::data_t      par_rdata,
  output logic                  queue_valid,
  output mpmem_pkg::row_t       queue_row,
  output mpmem_pkg::data_t      queue_data,
  output mpmem_pkg::data_t      par_word
);

  localparam int depth    = `MPMEM_QUEUE_DEPTH;
  localparam int cnt_bits = $clog2(depth + 1);

  logic                enq;
  mpmem_pkg::row_t     enq_row;
  mpmem_pkg::data_t    enq_data;
  logic [cnt_bits-1:0] cnt;
  mpmem_pkg::row_t     q_row  [depth];
  mpmem_pkg::data_t    q_data [depth];
  mpmem_pkg::row_t     srch_row;  // row of the conflicting read in its first stage
  logic                srch_hit;
  mpmem_pkg::data_t    srch_data;
  logic                fwd_hit;
  mpmem_pkg::data_t    fwd_data;

  assign enq     = sweep_active || wr_issue_out;
  assign enq_row = sweep_active ? sweep_row : wr_row_out;

  // new word in its own bank, returned old words in the others
  always_comb begin
    enq_data = '0;
    if (!sweep_active) begin
      for (int i = 0; i < `MPMEM_NUM_BANKS; i++) begin
        if (wr_bank_out == mpmem_pkg::bank_t'(i))
          enq_data = enq_data ^ wr_data_out;
        else
          enq_data = enq_data ^ bank_rdata[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      cnt <= '0;
    else
      cnt <= cnt + cnt_bits'(enq) - cnt_bits'(queue_deq);
  end

  // head is entry 0, a dequeue shifts the rest down
  always_ff @(posedge clk) begin
    for (int i = 0; i < depth; i++) begin
      if (enq && (int'(cnt) - int'(queue_deq) == i)) begin
        q_row[i]  <= enq_row;
        q_data[i] <= enq_data;
      end else if (queue_deq && i < depth - 1) begin
        q_row[i]  <= q_row[i+1];
        q_data[i] <= q_data[i+1];
      end
    end
  end

  assign queue_valid = (cnt != '0);
  assign queue_row   = q_row[0];
  assign queue_data  = q_data[0];

  always_ff @(posedge clk) begin
    if (par_re)
      srch_row <= par_row;
  end

  // later entries are newer, so the last match wins
  always_comb begin
    srch_hit  = 1'b0;
    srch_data = '0;
    for (int i = 0; i < depth; i++) begin
      if (int'(cnt) > i && q_row[i] == srch_row) begin
        srch_hit  = 1'b1;
        srch_data = q_data[i];
      end
    end
  end

  // an update landing in the second cycle is newer than anything queued
  always_ff @(posedge clk) begin
    if (rst) begin
      fwd_hit <= 1'b0;
    end else if (enq && enq_row == srch_row) begin
      fwd_hit <= 1'b1;
    end else begin
      fwd_hit <= srch_hit;
    end
  end

  always_ff @(posedge clk) begin
    fwd_data <= (enq && enq_row == srch_row) ? enq_data : srch_data;
  end

  assign par_word = fwd_hit ? fwd_data : par_rdata;

endmodule

/* logic/read_return.sv */
`timescale 1ns/1ps
`include "mpmem_defs.svh"

module read_return (
  input  logic                  rd0_issue_out,
  input  mpmem_pkg::bank_t      rd0_bank_out,
  input  logic                  rd1_issue_out,
  input  mpmem_pkg::bank_t      rd1_bank_out,
  input  logic                  rd1_conflict_out,
  input  mpmem_pkg::data_vec_t  bank_rdata,
  input  mpmem_pkg::data_t      par_word,
  output logic                  rd0_valid,
  output mpmem_pkg::data_t      rd0_data,
  output logic                  rd1_valid,
  output mpmem_pkg::data_t      rd1_data
);

  mpmem_pkg::data_t rebuilt;

  // port 1 lost its bank to port 0, rebuild from the rest of the row
  always_comb begin
    rebuilt = par_word;
    for (int i = 0; i < `MPMEM_NUM_BANKS; i++) begin
      if (rd1_bank_out != mpmem_pkg::bank_t'(i))
        rebuilt = rebuilt ^ bank_rdata[i];
    end
  end

  assign rd0_valid = rd0_issue_out;
  assign rd0_data  = bank_rdata[rd0_bank_out];
  assign rd1_valid = rd1_issue_out;
  assign rd1_data  = rd1_conflict_out ? rebuilt : bank_rdata[rd1_bank_out];

endmodule

/* logic/request_pipe.sv */
`timescale 1ns/1ps
`include "mpmem_defs.svh"

module request_pipe (
  input  logic              clk,
  input  logic              rst,
  input  logic              wr_issue,
  input  mpmem_pkg::bank_t  wr_bank,
  input  mpmem_pkg::row_t   wr_row,
  input  mpmem_pkg::data_t  wr_data,
  input  logic              rd0_issue,
  input  mpmem_pkg::bank_t  rd0_bank,
  input  logic              rd1_issue,
  input  mpmem_pkg::bank_t  rd1_bank,
  input  logic              rd1_conflict,
  output logic              wr_issue_out,
  output mpmem_pkg::bank_t  wr_bank_out,
  output mpmem_pkg::row_t   wr_row_out,
  output mpmem_pkg::data_t  wr_data_out,
  output logic              rd0_issue_out,
  output mpmem_pkg::bank_t  rd0_bank_out,
  output logic              rd1_issue_out,
  output mpmem_pkg::bank_t  rd1_bank_out,
  output logic              rd1_conflict_out
);

  localparam int stages = `MPMEM_SRAM_DELAY;

  logic [stages-1:0] wr_v;
  logic [stages-1:0] rd0_v;
  logic [stages-1:0] rd1_v;
  logic [stages-1:0] conf_v;
  mpmem_pkg::bank_t  wr_bank_q  [stages];
  mpmem_pkg::row_t   wr_row_q   [stages];
  mpmem_pkg::data_t  wr_data_q  [stages];
  mpmem_pkg::bank_t  rd0_bank_q [stages];
  mpmem_pkg::bank_t  rd1_bank_q [stages];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_v   <= '0;
      rd0_v  <= '0;
      rd1_v  <= '0;
      conf_v <= '0;
    end else begin
      wr_v   <= {wr_v[stages-2:0], wr_issue};
      rd0_v  <= {rd0_v[stages-2:0], rd0_issue};
      rd1_v  <= {rd1_v[stages-2:0], rd1_issue};
      conf_v <= {conf_v[stages-2:0], rd1_conflict};
    end
  end

  always_ff @(posedge clk) begin
    wr_bank_q[0]  <= wr_bank;
    wr_row_q[0]   <= wr_row;
    wr_data_q[0]  <= wr_data;
    rd0_bank_q[0] <= rd0_bank;
    rd1_bank_q[0] <= rd1_bank;
    for (int s = 1; s < stages; s++) begin
      wr_bank_q[s]  <= wr_bank_q[s-1];
      wr_row_q[s]   <= wr_row_q[s-1];
      wr_data_q[s]  <= wr_data_q[s-1];
      rd0_bank_q[s] <= rd0_bank_q[s-1];
      rd1_bank_q[s] <= rd1_bank_q[s-1];
    end
  end

  // last stage lines up with the bank read data
  assign wr_issue_out     = wr_v[stages-1];
  assign wr_bank_out      = wr_bank_q[stages-1];
  assign wr_row_out       = wr_row_q[stages-1];
  assign wr_data_out      = wr_data_q[stages-1];
  assign rd0_issue_out    = rd0_v[stages-1];
  assign rd0_bank_out     = rd0_bank_q[stages-1];
  assign rd1_issue_out    = rd1_v[stages-1];
  assign rd1_bank_out     = rd1_bank_q[stages-1];
  assign rd1_conflict_out = conf_v[stages-1];

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* test/tb_mpmem.sv */
`timescale 1ns/1ps
`include "mpmem_defs.svh"

module tb_mpmem;

  localparam int num_words   = 1 << `MPMEM_ADDR_BITS;
  localparam int reset_limit = 20;
  localparam int ready_limit = 200; // sweep and settle take about 70 cycles
  localparam int drain_limit = 8;

  logic             clk;
  logic             rst;
  logic             ready;
  logic             wr_en;
  mpmem_pkg::addr_t wr_addr;
  mpmem_pkg::data_t wr_data;
  logic             rd0_en;
  mpmem_pkg::addr_t rd0_addr;
  logic             rd1_en;
  mpmem_pkg::addr_t rd1_addr;
  logic             rd0_valid;
  mpmem_pkg::data_t rd0_data;
  logic             rd1_valid;
  mpmem_pkg::data_t rd1_data;

  mpmem_pkg::data_t model_mem [num_words];
  logic [1:0]       exp0_v; // index 1 is due in the current cycle
  logic [1:0]       exp1_v;
  mpmem_pkg::data_t exp0_d [2];
  mpmem_pkg::data_t exp1_d [2];
  logic             ready_seen; // requests are accepted from here on
  int               err_ctrl;
  int               err_data;
  logic             timed_out;
  logic [31:0]      rand_state;
  string            test_name;

  tb_clock u_clock (.clk(clk), .rst(rst));

  mpmem_top dut (
    .clk(clk), .rst(rst), .ready(ready),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd0_en(rd0_en), .rd0_addr(rd0_addr), .rd1_en(rd1_en), .rd1_addr(rd1_addr),
    .rd0_valid(rd0_valid), .rd0_data(rd0_data),
    .rd1_valid(rd1_valid), .rd1_data(rd1_data)
  );

  // reference model where a read sees only writes from earlier edges
  always @(posedge clk) begin
    if (rst) begin
      exp0_v <= '0;
      exp1_v <= '0;
      for (int i = 0; i < num_words; i++)
        model_mem[i] <= '0;
    end else begin
      exp0_v    <= {exp0_v[0], ready_seen && !wr_en && rd0_en};
      exp1_v    <= {exp1_v[0], ready_seen && !wr_en && rd1_en};
      exp0_d[0] <= model_mem[rd0_addr];
      exp0_d[1] <= exp0_d[0];
      exp1_d[0] <= model_mem[rd1_addr];
      exp1_d[1] <= exp1_d[0];
      if (ready_seen && wr_en)
        model_mem[wr_addr] <= wr_data;
    end
  end

  // sampled mid-cycle where outputs have settled
  assert property (@(negedge clk) disable iff (rst) rd0_valid == exp0_v[1])
    else begin
      err_ctrl++;
      $display("Error %s rd0_valid expected %0b actual %0b", test_name, exp0_v[1], rd0_valid);
    end
  assert property (@(negedge clk) disable iff (rst) rd1_valid == exp1_v[1])
    else begin
      err_ctrl++;
      $display("Error %s rd1_valid expected %0b actual %0b", test_name, exp1_v[1], rd1_valid);
    end
  assert property (@(negedge clk) disable iff (rst) exp0_v[1] |-> rd0_data == exp0_d[1])
    else begin
      err_data++;
      $display("Error %s rd0_data expected %h actual %h", test_name, exp0_d[1], rd0_data);
    end
  assert property (@(negedge clk) disable iff (rst) exp1_v[1] |-> rd1_data == exp1_d[1])
    else begin
      err_data++;
      $display("Error %s rd1_data expected %h actual %h", test_name, exp1_d[1], rd1_data);
    end

  // no back-pressure, so ready stays high once it has risen
  assert property (@(negedge clk) disable iff (rst) ready_seen |-> ready)
    else begin
      err_ctrl++;
      $display("Error %s ready expected 1 actual %0b", test_name, ready);
    end

  function automatic logic [31:0] next_random();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic mpmem_pkg::addr_t make_addr(input mpmem_pkg::row_t row,
                                                 input mpmem_pkg::bank_t bank);
    return {row, bank};
  endfunction

  // half of the addresses land in rows 0 to 3 so writes and conflicts overlap
  function automatic mpmem_pkg::addr_t pick_addr();
    logic [31:0] r;
    r = next_random();
    if (r[31])
      return make_addr(mpmem_pkg::row_t'(r[17:16]), mpmem_pkg::bank_t'(r[20:18]));
    return mpmem_pkg::addr_t'(r[24:16]);
  endfunction

  task automatic drive_cycle(
    input logic we, input mpmem_pkg::addr_t wa, input mpmem_pkg::data_t wd,
    input logic r0, input mpmem_pkg::addr_t a0, input logic r1, input mpmem_pkg::addr_t a1
  );
    @(posedge clk);
    wr_en    <= we;
    wr_addr  <= wa;
    wr_data  <= wd;
    rd0_en   <= r0;
    rd0_addr <= a0;
    rd1_en   <= r1;
    rd1_addr <= a1;
  endtask

  task automatic drive_idle();
    @(posedge clk);
    wr_en  <= 1'b0;
    rd0_en <= 1'b0;
    rd1_en <= 1'b0;
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst && n < reset_limit) begin
      @(posedge clk);
      n++;
    end
    if (rst) begin
      timed_out = 1'b1;
      $display("Timeout: reset was not released within %0d cycles", reset_limit);
    end
  endtask

  task automatic wait_for_ready();
    int n;
    n = 0;
    while (!ready && n < ready_limit) begin
      @(posedge clk);
      n++;
    end
    if (!ready) begin
      timed_out = 1'b1;
      $display("Timeout: ready did not rise within %0d cycles", ready_limit);
    end
  endtask

  // idle until every accepted read has returned and been checked
  task automatic drain_reads();
    int n;
    n = 0;
    drive_idle();
    @(negedge clk);
    while ((exp0_v != 2'b00 || exp1_v != 2'b00) && n < drain_limit) begin
      @(negedge clk);
      n++;
    end
    if (exp0_v != 2'b00 || exp1_v != 2'b00) begin
      timed_out = 1'b1;
      $display("Timeout: outstanding reads did not return within %0d cycles", drain_limit);
    end
  endtask

  initial begin
    logic [31:0]      r;
    mpmem_pkg::addr_t a0;
    mpmem_pkg::addr_t a1;
    mpmem_pkg::bank_t b;
    mpmem_pkg::row_t  row;
    mpmem_pkg::row_t  other;
    wr_en      = 1'b0;
    wr_addr    = '0;
    wr_data    = '0;
    rd0_en     = 1'b0;
    rd0_addr   = '0;
    rd1_en     = 1'b0;
    rd1_addr   = '0;
    ready_seen = 1'b0;
    err_ctrl   = 0;
    err_data   = 0;
    timed_out  = 1'b0;
    rand_state = 32'd56;
    test_name  = "reset";

    wait_reset_release();
    assert (!ready) else begin
      err_ctrl++;
      $display("Error %s ready expected 0 actual %0b", test_name, ready);
    end
    wait_for_ready();

    if (!timed_out) begin
      ready_seen <= 1'b1;

      test_name = "unwritten";
      for (int i = 0; i < 32; i++)
        drive_cycle(1'b0, '0, '0, 1'b1, pick_addr(), 1'b1, pick_addr());

      test_name = "write_read";
      for (int i = 0; i < 32; i++) begin
        a0 = pick_addr();
        drive_cycle(1'b1, a0, mpmem_pkg::data_t'(next_random() >> 16), 1'b0, '0, 1'b0, '0);
        drive_cycle(1'b0, '0, '0, i[0] || i[1], a0, !i[0], a0);
      end

      test_name = "diff_banks";
      for (int i = 0; i < 64; i++) begin
        r  = next_random();
        a0 = pick_addr();
        b  = a0[`MPMEM_BANK_BITS-1:0] + mpmem_pkg::bank_t'(1 + r[31:16] % 7);
        a1 = make_addr(mpmem_pkg::row_t'(r[27:22]), b);
        if (i % 4 == 0)
          drive_cycle(1'b1, a1, mpmem_pkg::data_t'(next_random() >> 16), 1'b0, '0, 1'b0, '0);
        drive_cycle(1'b0, '0, '0, 1'b1, a0, 1'b1, a1);
      end

      // reads given with each write must be dropped
      test_name = "conflict_after_write";
      for (int k = 0; k < 32; k++) begin
        r     = next_random();
        b     = mpmem_pkg::bank_t'(r[31:29]);
        row   = mpmem_pkg::row_t'(r[28:23]);
        other = row + mpmem_pkg::row_t'(1 + r[22:16] % 63);
        for (int j = 0; j < 3; j++) begin
          drive_cycle(1'b1, make_addr(row, b), mpmem_pkg::data_t'(next_random() >> 16),
                      1'b1, make_addr(other, b), 1'b1, make_addr(row, b));
          drive_cycle(1'b1, make_addr(row, mpmem_pkg::bank_t'(b + j + 1)),
                      mpmem_pkg::data_t'(next_random() >> 16),
                      1'b1, make_addr(row, b), 1'b0, '0);
        end
        repeat (k % 4) drive_idle();
        drive_cycle(1'b0, '0, '0, 1'b1, make_addr(other, b), 1'b1, make_addr(row, b));
        drive_cycle(1'b0, '0, '0, 1'b1, make_addr(row, b), 1'b1, make_addr(other, b));
      end

      test_name = "random_mix";
      for (int i = 0; i < 3000; i++) begin
        r  = next_random();
        a0 = pick_addr();
        a1 = pick_addr();
        case (r[31:29])
          3'd0, 3'd1:
            drive_cycle(1'b1, a0, mpmem_pkg::data_t'(next_random() >> 16), r[28], a1, r[27], a0);
          3'd2: drive_cycle(1'b0, '0, '0, 1'b1, a0, 1'b0, a1);
          3'd3: drive_cycle(1'b0, '0, '0, 1'b0, a0, 1'b1, a1);
          3'd4, 3'd5: drive_cycle(1'b0, '0, '0, 1'b1, a0, 1'b1, a1);
          3'd6: drive_cycle(1'b0, '0, '0, 1'b1, a0, 1'b1,
                            make_addr(a1[`MPMEM_ADDR_BITS-1:`MPMEM_BANK_BITS],
                                      a0[`MPMEM_BANK_BITS-1:0]));
          default: drive_idle();
        endcase
      end

      drain_reads();
    end

    $display("Errors: control %0d, data %0d, timeout %0d", err_ctrl, err_data, timed_out);
    if (!timed_out && err_ctrl == 0 && err_data == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule
